//--- logic/chroma_mc_cfg.svh
// sizes and offsets shared by the chroma MC engine
// included by the package and by every module that needs a width
`ifndef CHROMA_MC_CFG_SVH
`define CHROMA_MC_CFG_SVH

// pixel depth
`define CMC_PIX_W     8

// 4x4 output block, 8x8 chroma macroblock
`define CMC_BLK       4
`define CMC_MB_SIDE   8

// search window and macroblock origin inside it
`define CMC_SW_W      64
`define CMC_SW_H      64
`define CMC_SR_HOR    16
`define CMC_SR_VER    16

// motion vectors in eighth chroma pixels
`define CMC_MV_W      8
`define CMC_MV_FRAC   3

// pixels returned per memory read
`define CMC_RD_PIX    8

`endif

//--- logic/chroma_mc_pkg.sv
// types shared across the chroma MC engine
// compile ahead of the RTL modules, which import it
`include "chroma_mc_cfg.svh"

package chroma_mc_pkg;

  // macroblock partition, sets the quadrant to vector mapping
  typedef enum logic [1:0] {
    MB_16X16 = 2'd0,
    MB_16X8  = 2'd1,
    MB_8X16  = 2'd2,
    MB_8X8   = 2'd3
  } mb_type_e;

  typedef logic [`CMC_PIX_W-1:0] pix_t;

  // integer pel and eighth-pel parts of one vector component
  typedef struct packed {
    logic signed [`CMC_MV_W-`CMC_MV_FRAC-1:0] int_p;
    logic        [`CMC_MV_FRAC-1:0]           frac;
  } mv_fields_t;

  // the same word seen as a plain signed value or split into fields
  typedef union packed {
    logic signed [`CMC_MV_W-1:0] val;
    mv_fields_t                  f;
  } mv_comp_u;

  typedef struct packed {
    mv_comp_u y;
    mv_comp_u x;
  } mv_t;

  // search window read address, comp 0 is Cb and 1 is Cr
  typedef struct packed {
    logic [$clog2(`CMC_SW_W)-1:0] x;
    logic [$clog2(`CMC_SW_H)-1:0] y;
    logic                         comp;
  } rd_req_t;

  // two vertically adjacent reference rows plus the block fraction
  typedef struct packed {
    pix_t [`CMC_BLK:0]        top;
    pix_t [`CMC_BLK:0]        bot;
    logic [`CMC_MV_FRAC-1:0]  frac_x;
    logic [`CMC_MV_FRAC-1:0]  frac_y;
  } row_pair_t;

  typedef struct packed {
    pix_t [`CMC_BLK-1:0] pix;
  } pix_row_t;

  // 8x8 block, pixel (x,y) sits at index y*8+x
  typedef pix_t [`CMC_MB_SIDE*`CMC_MB_SIDE-1:0] blk_word_t;

endpackage

//--- logic/chroma_blk_seq.sv
// block sequencer of the chroma MC engine
// walks Cb then Cr, four quadrants each, five reference rows per quadrant,
// and keeps one search-window read pending until it is acknowledged
`timescale 1ns/1ns
`include "chroma_mc_cfg.svh"

module chroma_blk_seq (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       launch_i,
  input  chroma_mc_pkg::mb_type_e    mb_type_i,
  output logic [1:0]                 mv_addr_o,
  input  chroma_mc_pkg::mv_t         mv_i,
  input  logic                       rd_ack_i,
  output logic                       rd_en_o,
  output chroma_mc_pkg::rd_req_t     rd_req_o,
  output logic [`CMC_MV_FRAC-1:0]    frac_x_o,
  output logic [`CMC_MV_FRAC-1:0]    frac_y_o
);

  import chroma_mc_pkg::*;

  localparam int VW = `CMC_MV_W;
  localparam int XW = $clog2(`CMC_SW_W);
  localparam int YW = $clog2(`CMC_SW_H);

  typedef enum logic {
    S_IDLE,
    S_RUN
  } state_e;

  state_e        state_q;
  mb_type_e      mb_type_q;
  logic          comp_q;
  logic [1:0]    quad_q;
  logic [2:0]    row_q;
  logic          last_row;
  logic          last_quad;
  logic          row_done;
  logic [VW-1:0] pos_x;
  logic [VW-1:0] pos_y;

  assign rd_en_o   = (state_q == S_RUN);
  assign row_done  = rd_en_o && rd_ack_i;
  assign last_row  = (row_q == 3'(`CMC_BLK));
  assign last_quad = (quad_q == 2'd3);

  // ************************************************************************
  // control FSM and macroblock type
  // ************************************************************************

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      mb_type_q <= MB_16X16;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (launch_i) begin
            state_q   <= S_RUN;
            mb_type_q <= mb_type_i;
          end
        end
        S_RUN: begin
          // Cr, last quadrant, last row acknowledged
          if (row_done && last_row && last_quad && comp_q) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // row, quadrant and component counters all wrap back to zero
  // on the 40th acknowledge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      comp_q <= 1'b0;
      quad_q <= 2'd0;
      row_q  <= 3'd0;
    end else if (row_done) begin
      if (last_row) begin
        row_q  <= 3'd0;
        quad_q <= quad_q + 2'd1;
        if (last_quad) begin
          comp_q <= ~comp_q;
        end
      end else begin
        row_q <= row_q + 3'd1;
      end
    end
  end

  // ************************************************************************
  // vector index and read address
  // ************************************************************************

  always_comb begin
    case (mb_type_q)
      MB_16X16: mv_addr_o = 2'd0;
      MB_16X8:  mv_addr_o = {1'b0, quad_q[1]};
      MB_8X16:  mv_addr_o = {1'b0, quad_q[0]};
      default:  mv_addr_o = quad_q;
    endcase
  end

  // window origin + quadrant origin + integer vector (+ row for y)
  assign pos_x = VW'(`CMC_SR_HOR) + VW'({quad_q[0], 2'b00}) + VW'(mv_i.x.f.int_p);
  assign pos_y = VW'(`CMC_SR_VER) + VW'({quad_q[1], 2'b00}) + VW'(mv_i.y.f.int_p)
               + VW'(row_q);

  assign rd_req_o.x    = pos_x[XW-1:0];
  assign rd_req_o.y    = pos_y[YW-1:0];
  assign rd_req_o.comp = comp_q;

  // fraction of the block being fetched, sampled by the row loader
  assign frac_x_o = mv_i.x.f.frac;
  assign frac_y_o = mv_i.y.f.frac;

endmodule

//--- logic/chroma_ref_rows.sv
// reference row loader
// keeps the low five pixels of every returned row and, from the second
// row of a block on, hands the previous and current rows to the filter
`timescale 1ns/1ns
`include "chroma_mc_cfg.svh"

module chroma_ref_rows (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  rd_ack_i,
  input  chroma_mc_pkg::pix_t [`CMC_RD_PIX-1:0] rd_data_i,
  input  logic [`CMC_MV_FRAC-1:0]               frac_x_i,
  input  logic [`CMC_MV_FRAC-1:0]               frac_y_i,
  output logic                                  pair_v_o,
  output chroma_mc_pkg::row_pair_t              pair_o
);

  import chroma_mc_pkg::*;

  logic [2:0]        row_cnt_q;
  logic              pair_ld;
  pix_t [`CMC_BLK:0] cur_row;
  pix_t [`CMC_BLK:0] prev_q;

  // memory returns pixels from the requested x upward
  assign cur_row = rd_data_i[`CMC_BLK:0];
  assign pair_ld = rd_ack_i && (row_cnt_q != 3'd0);

  // acknowledges modulo five
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_cnt_q <= 3'd0;
      pair_v_o  <= 1'b0;
    end else begin
      pair_v_o <= pair_ld;
      if (rd_ack_i) begin
        if (row_cnt_q == 3'(`CMC_BLK)) begin
          row_cnt_q <= 3'd0;
        end else begin
          row_cnt_q <= row_cnt_q + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_ack_i) begin
      prev_q <= cur_row;
    end
  end

  // rows 1 to 4 close a pair with the row before
  always_ff @(posedge clk_i) begin
    if (pair_ld) begin
      pair_o.top    <= prev_q;
      pair_o.bot    <= cur_row;
      pair_o.frac_x <= frac_x_i;
      pair_o.frac_y <= frac_y_i;
    end
  end

endmodule

//--- logic/chroma_bilinear.sv
// eighth-pel bilinear chroma filter, two pipeline stages
// one row pair in, four filtered pixels out two cycles later
`timescale 1ns/1ns
`include "chroma_mc_cfg.svh"

module chroma_bilinear (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      pair_v_i,
  input  chroma_mc_pkg::row_pair_t  pair_i,
  output logic                      row_v_o,
  output chroma_mc_pkg::pix_row_t   row_o
);

  import chroma_mc_pkg::*;

  localparam int PW = `CMC_PIX_W;
  localparam int MW = 2 * PW;
  localparam int SH = 2 * `CMC_MV_FRAC;
  localparam int NP = `CMC_BLK;

  logic [MW-1:0]                fdx;
  logic [MW-1:0]                fdy;
  logic [MW-1:0]                cdx;
  logic [MW-1:0]                cdy;
  logic [3:0][MW-1:0]           wt;
  logic [NP-1:0][3:0][MW-1:0]   prod_q;
  logic                         prod_v_q;
  logic [NP-1:0][MW-1:0]        sum;

  // weights A..D, they always add up to 64
  assign fdx   = MW'(pair_i.frac_x);
  assign fdy   = MW'(pair_i.frac_y);
  assign cdx   = MW'(1 << `CMC_MV_FRAC) - fdx;
  assign cdy   = MW'(1 << `CMC_MV_FRAC) - fdy;
  assign wt[0] = cdx * cdy;
  assign wt[1] = fdx * cdy;
  assign wt[2] = cdx * fdy;
  assign wt[3] = fdx * fdy;

  // ************************************************************************
  // stage 1: weighted taps
  // ************************************************************************

  always_ff @(posedge clk_i) begin
    if (pair_v_i) begin
      for (int i = 0; i < NP; i++) begin
        prod_q[i][0] <= MW'(pair_i.top[i]) * wt[0];
        prod_q[i][1] <= MW'(pair_i.top[i + 1]) * wt[1];
        prod_q[i][2] <= MW'(pair_i.bot[i]) * wt[2];
        prod_q[i][3] <= MW'(pair_i.bot[i + 1]) * wt[3];
      end
    end
  end

  // ************************************************************************
  // stage 2: sum, round, scale back by 64
  // ************************************************************************

  always_comb begin
    for (int i = 0; i < NP; i++) begin
      sum[i] = prod_q[i][0] + prod_q[i][1] + prod_q[i][2] + prod_q[i][3]
             + MW'(1 << (SH - 1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (prod_v_q) begin
      for (int i = 0; i < NP; i++) begin
        row_o.pix[i] <= sum[i][SH +: PW];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prod_v_q <= 1'b0;
      row_v_o  <= 1'b0;
    end else begin
      prod_v_q <= pair_v_i;
      row_v_o  <= prod_v_q;
    end
  end

endmodule

//--- logic/chroma_out_buf.sv
// output buffer, assembles sixteen filtered rows into one 8x8 word
// and writes it once per component, Cb first, end of macroblock with Cr
`timescale 1ns/1ns
`include "chroma_mc_cfg.svh"

module chroma_out_buf (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      row_v_i,
  input  chroma_mc_pkg::pix_row_t   row_i,
  output logic                      wr_en_o,
  output logic                      wr_addr_o,
  output chroma_mc_pkg::blk_word_t  wr_data_o,
  output logic                      end_mb_o
);

  import chroma_mc_pkg::*;

  logic [3:0] row_cnt_q;
  logic       comp_q;
  logic       last_row;
  logic [2:0] dst_y;
  logic [2:0] dst_x;
  blk_word_t  buf_q;

  // counter is {quadrant, row}, quadrant bit 0 picks the x half
  assign dst_y    = {row_cnt_q[3], row_cnt_q[1:0]};
  assign dst_x    = {row_cnt_q[2], 2'b00};
  assign last_row = row_v_i && (row_cnt_q == 4'hf);

  always_ff @(posedge clk_i) begin
    if (row_v_i) begin
      for (int i = 0; i < `CMC_BLK; i++) begin
        buf_q[{dst_y, dst_x + 3'(i)}] <= row_i.pix[i];
      end
    end
  end

  // ************************************************************************
  // row count, write strobes, component toggle
  // ************************************************************************

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_cnt_q <= 4'd0;
      comp_q    <= 1'b0;
      wr_en_o   <= 1'b0;
      end_mb_o  <= 1'b0;
    end else begin
      wr_en_o  <= last_row;
      end_mb_o <= last_row && comp_q;
      if (row_v_i) begin
        row_cnt_q <= row_cnt_q + 4'd1;
      end
      // flip only after the write has gone out
      if (wr_en_o) begin
        comp_q <= ~comp_q;
      end
    end
  end

  assign wr_addr_o = comp_q;
  assign wr_data_o = buf_q;

endmodule

//--- logic/chroma_mc_top.sv
// chroma motion compensation top level
// sequencer, row loader, bilinear filter and output buffer in a chain,
// one macroblock per launch pulse
`timescale 1ns/1ns
`include "chroma_mc_cfg.svh"

module chroma_mc_top (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  launch_i,
  input  chroma_mc_pkg::mb_type_e               mb_type_i,
  output logic [1:0]                            mv_addr_o,
  input  chroma_mc_pkg::mv_t                    mv_i,
  output logic                                  rd_en_o,
  output chroma_mc_pkg::rd_req_t                rd_req_o,
  input  logic                                  rd_ack_i,
  input  chroma_mc_pkg::pix_t [`CMC_RD_PIX-1:0] rd_data_i,
  output logic                                  wr_en_o,
  output logic                                  wr_addr_o,
  output chroma_mc_pkg::blk_word_t              wr_data_o,
  output logic                                  end_mb_o
);

  import chroma_mc_pkg::*;

  logic [`CMC_MV_FRAC-1:0] frac_x;
  logic [`CMC_MV_FRAC-1:0] frac_y;
  logic                    pair_v;
  row_pair_t               pair;
  logic                    row_v;
  pix_row_t                row;

  chroma_blk_seq chroma_blk_seq_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .launch_i  (launch_i),
    .mb_type_i (mb_type_i),
    .mv_addr_o (mv_addr_o),
    .mv_i      (mv_i),
    .rd_ack_i  (rd_ack_i),
    .rd_en_o   (rd_en_o),
    .rd_req_o  (rd_req_o),
    .frac_x_o  (frac_x),
    .frac_y_o  (frac_y)
  );

  chroma_ref_rows chroma_ref_rows_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .rd_ack_i  (rd_ack_i),
    .rd_data_i (rd_data_i),
    .frac_x_i  (frac_x),
    .frac_y_i  (frac_y),
    .pair_v_o  (pair_v),
    .pair_o    (pair)
  );

  chroma_bilinear chroma_bilinear_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .pair_v_i (pair_v),
    .pair_i   (pair),
    .row_v_o  (row_v),
    .row_o    (row)
  );

  chroma_out_buf chroma_out_buf_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .row_v_i   (row_v),
    .row_i     (row),
    .wr_en_o   (wr_en_o),
    .wr_addr_o (wr_addr_o),
    .wr_data_o (wr_data_o),
    .end_mb_o  (end_mb_o)
  );

endmodule

//--- test/chroma_ref_model.svh
// reference model of the chroma MC engine, included in the testbench module
// holds the search window contents and works out expected reads and blocks
`ifndef CHROMA_REF_MODEL_SVH
`define CHROMA_REF_MODEL_SVH

// window contents, indexed [comp][y][x]
pix_t win_mem [2][`CMC_SW_H][`CMC_SW_W];

task automatic fill_window();
  for (int c = 0; c < 2; c++) begin
    for (int y = 0; y < `CMC_SW_H; y++) begin
      for (int x = 0; x < `CMC_SW_W; x++) begin
        win_mem[c][y][x] = pix_t'($urandom);
      end
    end
  end
endtask

// eight pixels from the requested x rightward, wrapping at the edge
function automatic rd_word_t read_row(rd_req_t req);
  rd_word_t row;
  for (int i = 0; i < `CMC_RD_PIX; i++) begin
    row[i] = win_mem[req.comp][req.y][(int'(req.x) + i) % `CMC_SW_W];
  end
  return row;
endfunction

// quadrant q to vector index for each partition type
function automatic int mv_index(mb_type_e t, int q);
  if (t == MB_16X16) return 0;
  if (t == MB_16X8) return q / 2;
  if (t == MB_8X16) return q % 2;
  return q;
endfunction

// read n of a macroblock, 20 per component and 5 per quadrant
function automatic rd_req_t expected_req(int n, mb_type_e t, mv_t [3:0] mvs);
  rd_req_t req;
  int      q;
  int      k;
  q = (n % 20) / 5;
  k = mv_index(t, q);
  req.x    = 6'(`CMC_SR_HOR + 4 * (q % 2) + (int'($signed(mvs[k].x.val)) >>> 3));
  req.y    = 6'(`CMC_SR_VER + 4 * (q / 2) + (int'($signed(mvs[k].y.val)) >>> 3) + n % 5);
  req.comp = 1'(n / 20);
  return req;
endfunction

function automatic pix_t bilin(pix_t a, pix_t b, pix_t c, pix_t d, int dx, int dy);
  int acc;
  acc = (8 - dx) * (8 - dy) * int'(a) + dx * (8 - dy) * int'(b)
      + (8 - dx) * dy * int'(c) + dx * dy * int'(d) + 32;
  return pix_t'(acc >>> 6);
endfunction

function automatic blk_word_t expected_block(int comp, mb_type_e t, mv_t [3:0] mvs);
  blk_word_t blk;
  int        mvx;
  int        mvy;
  int        px;
  int        py;
  for (int q = 0; q < 4; q++) begin
    mvx = int'($signed(mvs[mv_index(t, q)].x.val));
    mvy = int'($signed(mvs[mv_index(t, q)].y.val));
    for (int y = 0; y < 4; y++) begin
      for (int x = 0; x < 4; x++) begin
        px = `CMC_SR_HOR + 4 * (q % 2) + (mvx >>> 3) + x;
        py = `CMC_SR_VER + 4 * (q / 2) + (mvy >>> 3) + y;
        blk[(4 * (q / 2) + y) * 8 + 4 * (q % 2) + x] =
          bilin(win_mem[comp][py][px], win_mem[comp][py][px + 1],
                win_mem[comp][py + 1][px], win_mem[comp][py + 1][px + 1],
                mvx & 7, mvy & 7);
      end
    end
  end
  return blk;
endfunction

// zero vector, the block is the window at the macroblock origin
function automatic blk_word_t window_copy(int comp);
  blk_word_t blk;
  for (int y = 0; y < 8; y++) begin
    for (int x = 0; x < 8; x++) begin
      blk[y * 8 + x] = win_mem[comp][`CMC_SR_VER + y][`CMC_SR_HOR + x];
    end
  end
  return blk;
endfunction

`endif

//--- test/tb_chroma_mc.sv
// testbench for the chroma MC engine
// random macroblocks against a search-window memory with random acknowledge
// delays, checking every read request and every block write against a model
`timescale 1ns/1ns
`include "chroma_mc_cfg.svh"

module tb_chroma_mc;

  import chroma_mc_pkg::*;

  localparam int     PERIOD      = 40;
  localparam int     NUM_RAND    = 30;
  localparam int     NUM_MB      = NUM_RAND + 5;
  localparam int     READS_MB    = 40;
  localparam longint WATCHDOG_NS = longint'(NUM_MB + 5) * 200 * PERIOD;

  typedef pix_t [`CMC_RD_PIX-1:0] rd_word_t;

  logic       clk_i;
  logic       rst_n_i;
  logic       launch_i;
  mb_type_e   mb_type_i;
  logic [1:0] mv_addr_o;
  mv_t        mv_i;
  logic       rd_en_o;
  rd_req_t    rd_req_o;
  logic       rd_ack_i;
  rd_word_t   rd_data_i;
  logic       wr_en_o;
  logic       wr_addr_o;
  blk_word_t  wr_data_o;
  logic       end_mb_o;

  // macroblock in flight as the model sees it
  mv_t [3:0]  mv_tab;
  mb_type_e   cur_type;
  blk_word_t  exp_blk [2];
  int         reads_in_mb = 0;
  int         writes_in_mb = 0;
  int         mb_done = 0;
  time        last_ack_t = 0;
  logic       busy = 1'b0;

  `include "chroma_ref_model.svh"

  chroma_mc_top chroma_mc_top_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .launch_i  (launch_i),
    .mb_type_i (mb_type_i),
    .mv_addr_o (mv_addr_o),
    .mv_i      (mv_i),
    .rd_en_o   (rd_en_o),
    .rd_req_o  (rd_req_o),
    .rd_ack_i  (rd_ack_i),
    .rd_data_i (rd_data_i),
    .wr_en_o   (wr_en_o),
    .wr_addr_o (wr_addr_o),
    .wr_data_o (wr_data_o),
    .end_mb_o  (end_mb_o)
  );

  // vector table answers the index in the same cycle
  assign mv_i = mv_tab[mv_addr_o];

  always #(PERIOD / 2) clk_i = ~clk_i;

  task automatic stop_run(string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_blk(string name, blk_word_t got, blk_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_req(string name, rd_req_t got, rd_req_t exp);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_idx(string name, logic [1:0] got, logic [1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  function automatic mv_t rand_mv();
    mv_t m;
    m.x.val = 8'($urandom);
    m.y.val = 8'($urandom);
    return m;
  endfunction

  // ************************************************************************
  // search-window memory with 0 to 3 idle cycles before each acknowledge
  // ************************************************************************

  initial begin : mem_responder
    rd_req_t req;
    int      wait_n;
    rd_ack_i  = 1'b0;
    rd_data_i = '0;
    forever begin
      @(posedge clk_i);
      if (rd_ack_i) begin
        rd_ack_i <= 1'b0;
      end else if (rd_en_o) begin
        if (!busy || reads_in_mb >= READS_MB) begin
          stop_run("read request outside the 40 reads of a macroblock");
        end
        req = rd_req_o;
        check_idx("mv_addr_o", mv_addr_o, 2'(mv_index(cur_type, (reads_in_mb % 20) / 5)));
        check_req("rd_req_o", req, expected_req(reads_in_mb, cur_type, mv_tab));
        wait_n = $urandom_range(3);
        repeat (wait_n) begin
          @(posedge clk_i);
          // request must hold until acknowledged
          check_req("rd_req_o", rd_req_o, req);
        end
        rd_ack_i  <= 1'b1;
        rd_data_i <= read_row(req);
      end
    end
  end

  // read count, write order and final write timing
  always @(posedge clk_i) begin
    if (launch_i) begin
      reads_in_mb  = 0;
      writes_in_mb = 0;
      busy         = 1'b1;
    end
    if (rd_en_o && rd_ack_i) begin
      reads_in_mb++;
      last_ack_t = $time;
    end
    if (end_mb_o && !wr_en_o) begin
      stop_run("end_mb_o pulsed without a block write");
    end
    if (wr_en_o) begin
      if (!busy) begin
        stop_run("block write with no macroblock running");
      end
      check_bit("wr_addr_o", wr_addr_o, 1'(writes_in_mb));
      check_bit("end_mb_o", end_mb_o, 1'(writes_in_mb));
      check_blk("wr_data_o", wr_data_o, exp_blk[writes_in_mb]);
      writes_in_mb++;
      if (writes_in_mb == 2) begin
        if (reads_in_mb != READS_MB) begin
          stop_run($sformatf("%0d reads in one macroblock, expected %0d",
                             reads_in_mb, READS_MB));
        end
        if ($time - last_ack_t != time'(4 * PERIOD)) begin
          stop_run("final write not 4 cycles after the last acknowledge");
        end
        busy = 1'b0;
        mb_done++;
      end
    end
  end

  // one macroblock where copy_chk compares against a plain window copy
  task automatic run_mb(mb_type_e t, mv_t [3:0] mvs, logic copy_chk);
    int target;
    @(posedge clk_i);
    target = mb_done + 1;
    fill_window();
    cur_type = t;
    for (int c = 0; c < 2; c++) begin
      exp_blk[c] = copy_chk ? window_copy(c) : expected_block(c, t, mvs);
    end
    mv_tab    <= mvs;
    mb_type_i <= t;
    launch_i  <= 1'b1;
    @(posedge clk_i);
    launch_i  <= 1'b0;
    wait (mb_done == target);
  endtask

  // ************************************************************************
  // test sequence
  // ************************************************************************

  initial begin
    mv_t [3:0] mvs;
    void'($urandom(26));
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    launch_i  = 1'b0;
    mb_type_i = MB_16X16;
    mv_tab    = '0;
    cur_type  = MB_16X16;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    run_mb(MB_16X16, '0, 1'b1);

    // distinct integer x per index shows which vector each quadrant took
    for (int t = 0; t < 4; t++) begin
      for (int k = 0; k < 4; k++) begin
        mvs[k].x.val = 8'((k * 3 - 5) * 8 + int'($urandom_range(7)));
        mvs[k].y.val = 8'($urandom);
      end
      run_mb(mb_type_e'(2'(t)), mvs, 1'b0);
    end

    for (int n = 0; n < NUM_RAND; n++) begin
      for (int k = 0; k < 4; k++) begin
        mvs[k] = rand_mv();
      end
      run_mb(mb_type_e'(2'($urandom_range(3))), mvs, 1'b0);
    end

    // a few idle cycles so stray reads or writes still get caught
    repeat (4) @(posedge clk_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

  // watchdog sized from the number of macroblocks
  initial begin
    #(WATCHDOG_NS);
    stop_run($sformatf("timeout after %0d ns, engine stopped making progress",
                       WATCHDOG_NS));
  end

endmodule

//--- project.f
+incdir+logic
+incdir+test
logic/chroma_mc_pkg.sv
logic/chroma_blk_seq.sv
logic/chroma_ref_rows.sv
logic/chroma_bilinear.sv
logic/chroma_out_buf.sv
logic/chroma_mc_top.sv
test/tb_chroma_mc.sv

//--- Makefile
# Verilator build and run of the chroma MC testbench
VERILATOR ?= verilator
TOP       ?= tb_chroma_mc
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
